// ==== rtl/isqrt_settings.svh ====
`ifndef ISQRT_SETTINGS_SVH
`define ISQRT_SETTINGS_SVH

// Float word layout: sign, biased exponent, fraction
`define ISQ_EXP_W 8
`define ISQ_FRAC_W 18
`define ISQ_WORD_W 27

// Signed integer operand width
`define ISQ_INT_W 16

// Exponent bias, 2^0 encodes as 127
`define ISQ_BIAS 127

// Initial guess constant and 1.5 in 27-bit float
`define ISQ_MAGIC 27'd49920718
`define ISQ_THREE_HALVES 27'd33423360

// Result queue depth, also the credit pool size
`define ISQ_OUT_DEPTH 4

`endif

// ==== rtl/isqrt_pkg.sv ====
`include "isqrt_settings.svh"

package isqrt_pkg;

	// ========================================
	// Float word
	// ========================================
	// Value is (-1)^sign * 2^(exp-127) * 1.frac
	typedef struct packed {
		logic                   sign;
		logic [`ISQ_EXP_W-1:0]  exp;
		logic [`ISQ_FRAC_W-1:0] frac;
	} isqrt_float_t;

	// Integer view of the same word
	// Value sits in the low bits, pad above is ignored
	typedef struct packed {
		logic [`ISQ_WORD_W-`ISQ_INT_W-1:0] pad;
		logic signed [`ISQ_INT_W-1:0]      value;
	} isqrt_int_view_t;

	// ========================================
	// Operand word and host request
	// ========================================
	// One 27-bit word, decoded by the request flag
	typedef union packed {
		isqrt_float_t    f;
		isqrt_int_view_t i;
	} isqrt_operand_u;

	// Flag set means the operand is a signed integer
	typedef struct packed {
		logic           is_int;
		isqrt_operand_u operand;
	} isqrt_request_t;

endpackage

// ==== rtl/fp_mul.sv ====
`timescale 1ns/1ps
`include "isqrt_settings.svh"

module fp_mul (
	input  logic [`ISQ_WORD_W-1:0] a,
	input  logic [`ISQ_WORD_W-1:0] b,
	output logic [`ISQ_WORD_W-1:0] prod
);
	localparam int EW = `ISQ_EXP_W;
	localparam int MW = `ISQ_FRAC_W;

	logic            a_s;
	logic            b_s;
	logic [EW-1:0]   a_e;
	logic [EW-1:0]   b_e;
	// Hidden one on top, fraction LSB dropped
	logic [MW-1:0]   a_m;
	logic [MW-1:0]   b_m;
	logic [2*MW-1:0] raw;
	logic [EW:0]     exp_sum;
	logic [EW-1:0]   p_e;
	logic [MW-1:0]   p_f;
	logic            underflow;

	assign a_s = a[`ISQ_WORD_W-1];
	assign b_s = b[`ISQ_WORD_W-1];
	assign a_e = a[`ISQ_WORD_W-2 -: EW];
	assign b_e = b[`ISQ_WORD_W-2 -: EW];
	assign a_m = {1'b1, a[MW-1:1]};
	assign b_m = {1'b1, b[MW-1:1]};

	assign raw = a_m * b_m;
	assign exp_sum = a_e + b_e;

	// Product in [1,4), top bit set means one step right
	assign p_e = raw[2*MW-1] ? EW'(exp_sum - (`ISQ_BIAS - 1)) : EW'(exp_sum - `ISQ_BIAS);
	assign p_f = raw[2*MW-1] ? raw[2*MW-2 -: MW] : raw[2*MW-3 -: MW];

	// Unbiased sum below 1, flush
	assign underflow = exp_sum < (EW+1)'(`ISQ_BIAS + 1);

	// Zero exponent on either side reads as zero
	assign prod = (underflow || (a_e == '0) || (b_e == '0)) ? '0 : {a_s ^ b_s, p_e, p_f};

endmodule

// ==== rtl/fp_add.sv ====
`timescale 1ns/1ps
`include "isqrt_settings.svh"

module fp_add (
	input  logic                   iCLK,
	input  logic [`ISQ_WORD_W-1:0] a,
	input  logic [`ISQ_WORD_W-1:0] b,
	output logic [`ISQ_WORD_W-1:0] sum
);
	localparam int EW = `ISQ_EXP_W;
	localparam int MW = `ISQ_FRAC_W;
	// Aligned width: carry bit, mantissa, guard bits
	localparam int AW = 2 * MW + 1;
	localparam int SW = $clog2(AW + 1);

	// Stage one fields
	logic          a_s;
	logic          b_s;
	logic [EW-1:0] a_e;
	logic [EW-1:0] b_e;
	logic [MW-1:0] a_m;
	logic [MW-1:0] b_m;
	logic          a_larger;
	logic [EW-1:0] big_e;
	logic [EW-1:0] diff;
	logic [AW-1:0] a_al;
	logic [AW-1:0] b_al;
	logic [AW-1:0] pre_sum;
	// Stage boundary
	logic [AW-1:0]          s_pre_sum;
	logic [EW-1:0]          s_big_e;
	logic                   s_a_zero;
	logic                   s_b_zero;
	logic [`ISQ_WORD_W-1:0] s_a;
	logic [`ISQ_WORD_W-1:0] s_b;
	logic                   s_sign;
	// Stage two
	logic [SW-1:0]      shft;
	logic [AW+MW-2:0]   norm;
	logic [EW-1:0]      res_e;
	logic [MW-1:0]      res_f;
	logic               underflow;

	assign a_s = a[`ISQ_WORD_W-1];
	assign b_s = b[`ISQ_WORD_W-1];
	assign a_e = a[`ISQ_WORD_W-2 -: EW];
	assign b_e = b[`ISQ_WORD_W-2 -: EW];
	assign a_m = {1'b1, a[MW-1:1]};
	assign b_m = {1'b1, b[MW-1:1]};

	// ========================================
	// Stage 1, align and add
	// ========================================
	assign a_larger = (a_e > b_e) || ((a_e == b_e) && (a_m > b_m));
	assign big_e = a_larger ? a_e : b_e;
	assign diff = a_larger ? (a_e - b_e) : (b_e - a_e);

	// Smaller operand slides right, too far means nothing left
	assign a_al = a_larger ? {1'b0, a_m, {MW{1'b0}}} :
		(diff > EW'(AW - 2)) ? '0 : ({1'b0, a_m, {MW{1'b0}}} >> diff);
	assign b_al = !a_larger ? {1'b0, b_m, {MW{1'b0}}} :
		(diff > EW'(AW - 2)) ? '0 : ({1'b0, b_m, {MW{1'b0}}} >> diff);

	// Unlike signs subtract the smaller magnitude
	assign pre_sum = !(a_s ^ b_s) ? (a_al + b_al) :
		a_larger ? (a_al - b_al) : (b_al - a_al);

	always_ff @(posedge iCLK) begin
		s_pre_sum <= pre_sum;
		s_big_e <= big_e;
		s_a_zero <= (a_e == '0);
		s_b_zero <= (b_e == '0);
		s_a <= a;
		s_b <= b;
		s_sign <= a_larger ? a_s : b_s;
	end

	// ========================================
	// Stage 2, normalize
	// ========================================
	// Distance of the leading one from the top, AW when empty
	always_comb begin
		shft = SW'(AW);
		for (int i = 0; i < AW; i++) begin
			if (s_pre_sum[i])
				shft = SW'(AW - 1 - i);
		end
	end

	// Extra position drops the hidden one
	assign norm = {s_pre_sum, {(MW-1){1'b0}}} << (shft + 1'b1);
	assign res_f = norm[AW+MW-2 -: MW];
	assign res_e = s_big_e + EW'(1) - EW'(shft);
	// Exponent would reach zero or below
	assign underflow = ({1'b0, s_big_e} + (EW+1)'(1)) <= (EW+1)'(shft);

	always_ff @(posedge iCLK) begin
		sum <= (s_a_zero && s_b_zero) ? '0 :
			s_a_zero ? s_b :
			s_b_zero ? s_a :
			(s_pre_sum == '0) ? '0 :
			underflow ? '0 :
			{s_sign, res_e, res_f};
	end

endmodule

// ==== rtl/isqrt_operand_rx.sv ====
`timescale 1ns/1ps
`include "isqrt_settings.svh"

module isqrt_operand_rx (
	input  logic                      iCLK,
	input  logic                      rst_n,
	input  logic                      in_req,
	input  isqrt_pkg::isqrt_request_t in_data,
	output logic                      in_ack,
	input  logic                      credit_return,
	output logic                      op_valid,
	output isqrt_pkg::isqrt_float_t   op_value
);
	import isqrt_pkg::*;

	localparam int CRED_W = $clog2(`ISQ_OUT_DEPTH + 1);
	localparam int POS_W = $clog2(`ISQ_INT_W);

	// Credit pool, one per free queue slot downstream
	logic [CRED_W-1:0]                 credits;
	logic                              accept;
	// Integer to float path
	logic                              int_neg;
	logic [`ISQ_INT_W-1:0]             int_mag;
	logic [POS_W-1:0]                  lead_pos;
	logic [`ISQ_INT_W+`ISQ_FRAC_W-1:0] int_shift;
	isqrt_float_t                      int_float;
	isqrt_float_t                      entry_float;

	// Take the operand only on a fresh req with a credit in hand
	assign accept = in_req && !in_ack && (credits != '0);

	// ========================================
	// Integer normalizer
	// ========================================
	always_comb begin
		int_neg = in_data.operand.i.value[`ISQ_INT_W-1];
		// Magnitude, -32768 still fits as unsigned
		int_mag = int_neg ? -in_data.operand.i.value : in_data.operand.i.value;
		// Highest set bit wins
		lead_pos = '0;
		for (int b = 0; b < `ISQ_INT_W; b++) begin
			if (int_mag[b])
				lead_pos = POS_W'(b);
		end
		// Move the leading one to just above the fraction field
		int_shift = {{`ISQ_FRAC_W{1'b0}}, int_mag} << (`ISQ_FRAC_W - lead_pos);
		int_float.sign = int_neg;
		int_float.exp = `ISQ_EXP_W'(`ISQ_BIAS + lead_pos);
		int_float.frac = int_shift[`ISQ_FRAC_W-1:0];
		// Zero has no leading one
		if (int_mag == '0)
			int_float = '0;
		entry_float = in_data.is_int ? int_float : in_data.operand.f;
	end

	// ========================================
	// Handshake and credits
	// ========================================
	always_ff @(posedge iCLK or negedge rst_n) begin
		if (!rst_n) begin
			in_ack <= 1'b0;
			op_valid <= 1'b0;
			credits <= CRED_W'(`ISQ_OUT_DEPTH);
		end else begin
			op_valid <= accept;
			// Ack up on capture, down once req is seen low
			if (accept)
				in_ack <= 1'b1;
			else if (!in_req)
				in_ack <= 1'b0;
			// Spend and refund can land on the same edge
			credits <= credits - CRED_W'(accept) + CRED_W'(credit_return);
		end
	end

	// Converted operand into the pipeline
	always_ff @(posedge iCLK) begin
		if (accept)
			op_value <= entry_float;
	end

endmodule

// ==== rtl/fp_inv_sqrt.sv ====
`timescale 1ns/1ps
`include "isqrt_settings.svh"

module fp_inv_sqrt (
	input  logic                    iCLK,
	input  logic                    rst_n,
	input  logic                    op_valid,
	input  isqrt_pkg::isqrt_float_t op_value,
	output logic                    res_valid,
	output isqrt_pkg::isqrt_float_t res_value
);
	import isqrt_pkg::*;

	localparam int W = `ISQ_WORD_W;
	// y waits from stage 2 until the adder result appears
	localparam int Y_DLY = 4;

	logic [W-1:0]  op_bits;
	logic [W-1:0]  y_1;
	isqrt_float_t  half_1;
	logic [W-1:0]  y_sq_1;
	logic [W-1:0]  y_dly [Y_DLY];
	logic [W-1:0]  sq_2;
	isqrt_float_t  half_2;
	logic [W-1:0]  term_2;
	logic [W-1:0]  term_3;
	logic [W-1:0]  neg_term;
	logic [W-1:0]  diff_5;
	logic [W-1:0]  refined;
	logic [Y_DLY-1:0] vld_sr;

	// ========================================
	// Stage 1, guess and y squared
	// ========================================
	assign op_bits = op_value;
	// Bit trick on the raw word
	assign y_1 = `ISQ_MAGIC - (op_bits >> 1);

	// x/2 by one less on the exponent
	always_comb begin
		half_1 = op_value;
		half_1.exp = op_value.exp - 1'b1;
	end

	fp_mul u_sq (.a(y_1), .b(y_1), .prod(y_sq_1));

	// Stage 2, x/2 times y^2
	fp_mul u_term (.a(half_2), .b(sq_2), .prod(term_2));

	// Stages 3 and 4, 1.5 - term
	assign neg_term = {~term_3[W-1], term_3[W-2:0]};
	fp_add u_diff (.iCLK(iCLK), .a(neg_term), .b(`ISQ_THREE_HALVES), .sum(diff_5));

	// Stage 5, Newton step y * (1.5 - x/2 * y^2)
	fp_mul u_refine (.a(y_dly[Y_DLY-1]), .b(diff_5), .prod(refined));

	// ========================================
	// Pipeline registers
	// ========================================
	always_ff @(posedge iCLK) begin
		sq_2 <= y_sq_1;
		half_2 <= half_1;
		term_3 <= term_2;
		// y kept in step with the two-cycle adder
		y_dly[0] <= y_1;
		for (int i = 1; i < Y_DLY; i++)
			y_dly[i] <= y_dly[i-1];
		res_value <= refined;
	end

	// Valid rides alongside, result lands 5 cycles on
	always_ff @(posedge iCLK or negedge rst_n) begin
		if (!rst_n) begin
			vld_sr <= '0;
			res_valid <= 1'b0;
		end else begin
			vld_sr <= {vld_sr[Y_DLY-2:0], op_valid};
			res_valid <= vld_sr[Y_DLY-1];
		end
	end

endmodule

// ==== rtl/isqrt_result_tx.sv ====
`timescale 1ns/1ps
`include "isqrt_settings.svh"

module isqrt_result_tx (
	input  logic                    iCLK,
	input  logic                    rst_n,
	input  logic                    res_valid,
	input  isqrt_pkg::isqrt_float_t res_value,
	output logic                    out_req,
	output isqrt_pkg::isqrt_float_t out_data,
	input  logic                    out_ack,
	output logic                    credit_return
);
	import isqrt_pkg::*;

	localparam int DEPTH = `ISQ_OUT_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	isqrt_float_t     queue [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	// Set from ack seen until ack drops
	logic             ack_wait;
	logic             launch;
	logic             pop;

	// Wrap at the queue end
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		next_ptr = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Idle sender with a result waiting
	assign launch = !out_req && !ack_wait && (count != '0);
	// Host has the data, retire the head
	assign pop = out_req && out_ack;

	// ========================================
	// Queue storage
	// ========================================
	always_ff @(posedge iCLK) begin
		if (res_valid)
			queue[wr_ptr] <= res_value;
		// Head held stable for the whole req phase
		if (launch)
			out_data <= queue[rd_ptr];
	end

	// ========================================
	// Pointers and four-phase sender
	// ========================================
	always_ff @(posedge iCLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_req <= 1'b0;
			ack_wait <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			if (res_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// No overflow, credits bound the writes
			count <= count + CNT_W'(res_valid) - CNT_W'(pop);
			if (launch)
				out_req <= 1'b1;
			else if (pop)
				out_req <= 1'b0;
			if (pop)
				ack_wait <= 1'b1;
			else if (ack_wait && !out_ack)
				ack_wait <= 1'b0;
			// Slot freed, hand a credit back
			credit_return <= pop;
		end
	end

endmodule

// ==== rtl/isqrt_top.sv ====
`timescale 1ns/1ps
`include "isqrt_settings.svh"

module isqrt_top (
	input  logic                      iCLK,
	input  logic                      rst_n,
	input  logic                      in_req,
	input  isqrt_pkg::isqrt_request_t in_data,
	output logic                      in_ack,
	output logic                      out_req,
	output isqrt_pkg::isqrt_float_t   out_data,
	input  logic                      out_ack
);
	import isqrt_pkg::*;

	// Operand into the pipeline
	logic         op_valid;
	isqrt_float_t op_value;
	// Result into the queue
	logic         res_valid;
	isqrt_float_t res_value;
	// Freed queue slot back to the input side
	logic         credit_return;

	// ========================================
	// Input side, pipeline, output side
	// ========================================
	isqrt_operand_rx u_rx (
		.iCLK          (iCLK),
		.rst_n         (rst_n),
		.in_req        (in_req),
		.in_data       (in_data),
		.in_ack        (in_ack),
		.credit_return (credit_return),
		.op_valid      (op_valid),
		.op_value      (op_value)
	);

	fp_inv_sqrt u_core (
		.iCLK      (iCLK),
		.rst_n     (rst_n),
		.op_valid  (op_valid),
		.op_value  (op_value),
		.res_valid (res_valid),
		.res_value (res_value)
	);

	isqrt_result_tx u_tx (
		.iCLK          (iCLK),
		.rst_n         (rst_n),
		.res_valid     (res_valid),
		.res_value     (res_value),
		.out_req       (out_req),
		.out_data      (out_data),
		.out_ack       (out_ack),
		.credit_return (credit_return)
	);

endmodule

// ==== sim/isqrt_checker.sv ====
`timescale 1ns/1ps
`include "isqrt_settings.svh"

module isqrt_checker (
	input  logic                      iCLK,
	input  logic                      rst_n,
	input  logic                      in_req,
	input  isqrt_pkg::isqrt_request_t in_data,
	input  logic                      in_ack,
	input  logic                      out_req,
	input  isqrt_pkg::isqrt_float_t   out_data,
	input  logic                      out_ack,
	input  int                        n_tests,
	output int                        value_errors,
	output int                        protocol_errors,
	output int                        results_seen,
	output logic                      timed_out
);
	import isqrt_pkg::*;

	// Expected results in input order
	string                  exp_name [$];
	logic [`ISQ_WORD_W-1:0] exp_value [$];
	// Values seen at the previous edge
	logic                   prev_ireq;
	logic                   prev_iack;
	logic                   prev_oreq;
	logic                   prev_oack;
	isqrt_request_t         prev_idata;
	isqrt_float_t           prev_odata;
	logic                   seen_req;
	int                     cycles;

	task automatic add_expected(input string name, input logic [`ISQ_WORD_W-1:0] value);
		exp_name.push_back(name);
		exp_value.push_back(value);
	endtask

	task automatic protocol_error(input string what);
		protocol_errors++;
		$display("Protocol error at %0t ns: %s", $time, what);
	endtask

	initial begin
		value_errors = 0;
		protocol_errors = 0;
		results_seen = 0;
		timed_out = 1'b0;
		cycles = 0;
	end

	// ========================================
	// Timeout
	// ========================================
	always @(posedge iCLK) begin
		cycles++;
		if (!timed_out && cycles > n_tests * 20 + 100) begin
			timed_out = 1'b1;
			$display("Timeout: run did not finish within %0d cycles", n_tests * 20 + 100);
		end
	end

	// ========================================
	// Handshake order and result compare
	// ========================================
	// Host signals move just after an edge, against the current sample
	// DUT signals move on the edge, against what the DUT saw there
	always @(posedge iCLK) begin
		if (!rst_n) begin
			prev_ireq <= 1'b0;
			prev_iack <= 1'b0;
			prev_oreq <= 1'b0;
			prev_oack <= 1'b0;
			seen_req <= 1'b0;
		end else begin
			// Nothing moves before the host asks
			if (!seen_req && !in_req && (in_ack || out_req))
				protocol_error("in_ack or out_req rose before any in_req");
			if (in_req)
				seen_req <= 1'b1;
			// Input side
			if (in_req && !prev_ireq && in_ack)
				protocol_error("in_req rose while in_ack was still high");
			if (in_ack && !prev_iack && !prev_ireq)
				protocol_error("in_ack rose without in_req");
			if (!in_req && prev_ireq && !in_ack)
				protocol_error("in_req fell before in_ack");
			if (!in_ack && prev_iack && prev_ireq)
				protocol_error("in_ack fell while in_req was high");
			if (in_req && prev_ireq && in_data != prev_idata)
				protocol_error("in_data changed while in_req was high");
			// Output side
			if (out_req && !prev_oreq && prev_oack)
				protocol_error("out_req rose while out_ack was still high");
			if (out_ack && !prev_oack && !out_req)
				protocol_error("out_ack rose without out_req");
			if (!out_req && prev_oreq && !prev_oack)
				protocol_error("out_req fell before out_ack");
			if (!out_ack && prev_oack && out_req)
				protocol_error("out_ack fell while out_req was high");
			if (out_req && prev_oreq && out_data != prev_odata)
				protocol_error("out_data changed while out_req was high");
			// Result taken on the first ack
			if (out_req && out_ack && !prev_oack) begin
				if (results_seen >= exp_value.size())
					protocol_error("a result arrived with no test left to match it");
				else if (out_data !== exp_value[results_seen]) begin
					value_errors++;
					$display("FAIL %s expected %h actual %h",
						exp_name[results_seen], exp_value[results_seen], out_data);
				end
				results_seen++;
			end
			prev_ireq <= in_req;
			prev_iack <= in_ack;
			prev_oreq <= out_req;
			prev_oack <= out_ack;
			prev_idata <= in_data;
			prev_odata <= out_data;
		end
	end

endmodule

// ==== sim/isqrt_tb.sv ====
`timescale 1ns/1ps
`include "isqrt_settings.svh"

module isqrt_tb;
	import isqrt_pkg::*;

	logic                   iCLK;
	logic                   rst_n;
	logic                   in_req;
	isqrt_request_t         in_data;
	logic                   in_ack;
	logic                   out_req;
	isqrt_float_t           out_data;
	logic                   out_ack;
	// Test table from the data file
	logic                   is_int_q [$];
	logic [`ISQ_WORD_W-1:0] operand_q [$];
	int                     n_tests;
	int                     value_errors;
	int                     protocol_errors;
	int                     results_seen;
	int                     missing;
	logic                   timed_out;
	logic [31:0]            lfsr;

	isqrt_top DUT (
		.iCLK(iCLK), .rst_n(rst_n),
		.in_req(in_req), .in_data(in_data), .in_ack(in_ack),
		.out_req(out_req), .out_data(out_data), .out_ack(out_ack)
	);

	isqrt_checker chk (
		.iCLK(iCLK), .rst_n(rst_n),
		.in_req(in_req), .in_data(in_data), .in_ack(in_ack),
		.out_req(out_req), .out_data(out_data), .out_ack(out_ack),
		.n_tests(n_tests), .value_errors(value_errors),
		.protocol_errors(protocol_errors), .results_seen(results_seen),
		.timed_out(timed_out)
	);

	// 100 ns period
	always #50 iCLK = ~iCLK;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Inputs change just after the edge
	task automatic next_cycle();
		@(posedge iCLK);
		#1;
	endtask

	task automatic load_tests();
		int fd;
		int got;
		int flag;
		string line;
		string name;
		logic [`ISQ_WORD_W-1:0] op;
		logic [`ISQ_WORD_W-1:0] expv;
		fd = $fopen("sim/isqrt_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file sim/isqrt_tests.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Skip comments and blank lines
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			got = $sscanf(line, "%s %d %h %h", name, flag, op, expv);
			if (got == 4) begin
				is_int_q.push_back(flag != 0);
				operand_q.push_back(op);
				chk.add_expected(name, expv);
			end
		end
		$fclose(fd);
	endtask

	// Host side of the input four-phase handshake
	task automatic drive_all();
		for (int t = 0; t < n_tests; t++) begin
			while (in_ack)
				next_cycle();
			in_data.is_int = is_int_q[t];
			in_data.operand = operand_q[t];
			in_req = 1'b1;
			next_cycle();
			while (!in_ack)
				next_cycle();
			in_req = 1'b0;
			next_cycle();
		end
	endtask

	// Host side of the output handshake, ack held back 0 to 7 cycles
	task automatic ack_loop();
		int d;
		forever begin
			next_cycle();
			if (out_req && !out_ack) begin
				d = 0;
				for (int k = 0; k < 3; k++) begin
					lfsr = lfsr_next(lfsr);
					d = (d << 1) | lfsr[0];
				end
				repeat (d)
					next_cycle();
				out_ack = 1'b1;
				while (out_req)
					next_cycle();
				out_ack = 1'b0;
			end
		end
	endtask

	initial begin
		iCLK = 1'b0;
		rst_n = 1'b0;
		in_req = 1'b0;
		in_data = '0;
		out_ack = 1'b0;
		lfsr = 32'h63ee;
		n_tests = 0;
		load_tests();
		n_tests = operand_q.size();
		if (n_tests == 0)
			$display("No tests were read from the test file");
		repeat (5) @(posedge iCLK);
		#1;
		rst_n = 1'b1;
		if (n_tests > 0) begin
			fork
				ack_loop();
			join_none
			// Quiet period checks that nothing moves on its own
			repeat (3) next_cycle();
			fork
				drive_all();
			join_none
			wait (results_seen >= n_tests || timed_out);
			// Drain, catches any extra result
			if (!timed_out)
				repeat (10) next_cycle();
		end
		missing = (results_seen < n_tests) ? n_tests - results_seen : 0;
		$display("Errors: value %0d, protocol %0d, missing results %0d, timeout %0d",
			value_errors, protocol_errors, missing, timed_out);
		if (n_tests > 0 && value_errors == 0 && protocol_errors == 0 && !timed_out
			&& results_seen == n_tests)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== sim/isqrt_tests.txt ====
# Columns: test name, is_int flag (0 float, 1 integer), operand hex, expected result hex
# Float words are sign, 8-bit exponent (bias 127) and 18-bit fraction
f_one_64th      0 1E40000 207FC85
f_one_16th      0 1EC0000 203FC85
f_one_quarter   0 1F40000 1FFFC85
f_one           0 1FC0000 1FBFC85
f_four          0 2040000 1F7FC85
f_sixteen       0 20C0000 1F3FC85
f_sixty_four    0 2140000 1EFFC85
f_two_fifty_six 0 21C0000 1EBFC85
f_two_pow_20    0 24C0000 1D3FC85
f_one_eighth    0 1F00000 201A7CC
f_one_half      0 1F80000 1FDA7CC
f_two           0 2000000 1F9A7CC
f_eight         0 2080000 1F5A7CC
f_thirty_two    0 2100000 1F1A7CC
i_one           1 0000001 1FBFC85
i_two           1 0000002 1F9A7CC
i_four          1 0000004 1F7FC85
i_eight         1 0000008 1F5A7CC
i_sixteen       1 0000010 1F3FC85
i_thirty_two    1 0000020 1F1A7CC
i_sixty_four    1 0000040 1EFFC85
i_512           1 0000200 1E9A7CC
i_1024          1 0000400 1E7FC85
i_2048          1 0000800 1E5A7CC
i_16384         1 0004000 1DFFC85
i_pad_sixteen   1 5550010 1F3FC85

// ==== flist.f ====
+incdir+rtl
rtl/isqrt_pkg.sv
rtl/fp_mul.sv
rtl/fp_add.sv
rtl/isqrt_operand_rx.sv
rtl/fp_inv_sqrt.sv
rtl/isqrt_result_tx.sv
rtl/isqrt_top.sv
sim/isqrt_checker.sv
sim/isqrt_tb.sv

// ==== Bender.yml ====
package:
  name: isqrt

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isqrt_pkg.sv
      - rtl/fp_mul.sv
      - rtl/fp_add.sv
      - rtl/isqrt_operand_rx.sv
      - rtl/fp_inv_sqrt.sv
      - rtl/isqrt_result_tx.sv
      - rtl/isqrt_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/isqrt_checker.sv
      - sim/isqrt_tb.sv
